// ==== rtl/alu.sv ====
// Shifts use only the low five bits of b and SLT compares signed
`timescale 1ns/1ps
`default_nettype none

module alu import mips_isa_pkg::*; (
    input  wire logic [XLEN-1:0] a_i,
    input  wire logic [XLEN-1:0] b_i,
    input  wire alu_op_e         op_i,
    output logic      [XLEN-1:0] result_o,
    output logic                 zero_o
);

    always_comb begin
        case (op_i)
            ALU_ADD: result_o = a_i + b_i;
            ALU_SUB: result_o = a_i - b_i;
            ALU_AND: result_o = a_i & b_i;
            ALU_OR:  result_o = a_i | b_i;
            ALU_SLT: result_o = {{(XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
            ALU_SLL: result_o = a_i << b_i[SHAMT_W-1:0];
            default: result_o = '0;
        endcase
    end

    // Branch compare relies on the subtract result
    assign zero_o = (result_o == '0);

endmodule

`default_nettype wire

// ==== rtl/decode.sv ====
// Unknown opcodes and funct codes give an all-zero control set and act as a no-op
`timescale 1ns/1ps
`default_nettype none

module decode import mips_isa_pkg::*, pipe_pkg::*; (
    input  wire logic [XLEN-1:0]    instr_i,
    output ctrl_t                   ctrl_o,
    output logic      [REG_AW-1:0]  rs_o,
    output logic      [REG_AW-1:0]  rt_o,
    output logic      [REG_AW-1:0]  dest_o,
    output logic      [XLEN-1:0]    sign_imm_o,
    output logic      [SHAMT_W-1:0] shamt_o,
    output logic      [TGT_W+1:0]   jump_target_o
);

    logic [OPC_W-1:0]   opcode;
    logic [FUNCT_W-1:0] funct;
    logic [REG_AW-1:0]  rs;
    logic [REG_AW-1:0]  rd;
    logic               rtype;

    assign opcode     = instr_i[OPC_LSB +: OPC_W];
    assign funct      = instr_i[FUNCT_W-1:0];
    assign rs         = instr_i[RS_LSB +: REG_AW];
    assign rd         = instr_i[RD_LSB +: REG_AW];
    assign rt_o       = instr_i[RT_LSB +: REG_AW];
    assign shamt_o    = instr_i[SHAMT_LSB +: SHAMT_W];
    assign sign_imm_o = {{(XLEN-IMM_W){instr_i[IMM_W-1]}}, instr_i[IMM_W-1:0]};
    assign rtype      = (opcode == OP_RTYPE);

    // Offset inside the 256 MB region; the top supplies the upper pc bits
    assign jump_target_o = {instr_i[TGT_W-1:0], 2'b00};

    always_comb begin
        ctrl_o = '0;
        case (opcode)
            OP_RTYPE: begin
                ctrl_o.reg_wr = 1'b1;
                case (funct)
                    F_ADDU:  ctrl_o.alu_op = ALU_ADD;
                    F_SUBU:  ctrl_o.alu_op = ALU_SUB;
                    F_AND:   ctrl_o.alu_op = ALU_AND;
                    F_OR:    ctrl_o.alu_op = ALU_OR;
                    F_SLT:   ctrl_o.alu_op = ALU_SLT;
                    F_SLL: begin
                        ctrl_o.alu_op  = ALU_SLL;
                        ctrl_o.alu_src = SRC_SHAMT;
                    end
                    default: ctrl_o.reg_wr = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                ctrl_o.reg_wr  = 1'b1;
                ctrl_o.alu_src = SRC_IMM;
            end
            OP_LW: begin
                ctrl_o.reg_wr     = 1'b1;
                ctrl_o.mem_rd     = 1'b1;
                ctrl_o.mem_to_reg = 1'b1;
                ctrl_o.alu_src    = SRC_IMM;
            end
            OP_SW: begin
                ctrl_o.mem_wr  = 1'b1;
                ctrl_o.alu_src = SRC_IMM;
            end
            OP_BEQ, OP_BNE: begin
                ctrl_o.branch    = 1'b1;
                ctrl_o.branch_ne = (opcode == OP_BNE);
                ctrl_o.alu_op    = ALU_SUB;
            end
            OP_J:    ctrl_o.jump = 1'b1;
            default: ctrl_o = '0;
        endcase
    end

    // SLL shifts rt, so route it through the first operand port
    assign rs_o = (ctrl_o.alu_src == SRC_SHAMT) ? rt_o : rs;

    assign dest_o = !ctrl_o.reg_wr ? '0 : (rtype ? rd : rt_o);

endmodule

`default_nettype wire

// ==== rtl/fetch_stage.sv ====
// Branch redirect beats stall and jump; run_i low parks the pc at zero and fetches nothing
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import mips_isa_pkg::*; (
    input  wire logic [XLEN-1:0] jump_target_i,
    input  wire logic [XLEN-1:0] branch_target_i,
    input  wire logic            clk,
    input  wire logic            rst_n_i,
    input  wire logic            run_i,
    input  wire logic            stall_i,
    input  wire logic            jump_i,
    input  wire logic            branch_taken_i,
    output logic      [XLEN-1:0] pc_o,
    output logic                 fetch_valid_o
);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_o <= '0;
        end else if (!run_i) begin
            pc_o <= '0;
        end else if (branch_taken_i) begin
            pc_o <= branch_target_i;
        end else if (!stall_i) begin
            pc_o <= jump_i ? jump_target_i : pc_o + 32'd4;
        end
    end

    assign fetch_valid_o = run_i;

endmodule

`default_nettype wire

// ==== rtl/hazard_unit.sv ====
// Assumes a destination index of zero means no register write; loads in memory are not forwarded
`timescale 1ns/1ps
`default_nettype none

module hazard_unit import mips_isa_pkg::*, pipe_pkg::*; (
    input  wire logic [REG_AW-1:0] ex_rs_i,
    input  wire logic [REG_AW-1:0] ex_rt_i,
    input  wire logic [REG_AW-1:0] id_rs_i,
    input  wire logic [REG_AW-1:0] id_rt_i,
    input  wire logic [REG_AW-1:0] ex_dest_i,
    input  wire logic              ex_mem_rd_i,
    input  wire logic [REG_AW-1:0] mem_dest_i,
    input  wire logic              mem_reg_wr_i,
    input  wire logic [REG_AW-1:0] wb_dest_i,
    input  wire logic              wb_reg_wr_i,
    input  wire logic              branch_taken_i,
    input  wire logic              jump_i,
    output fwd_sel_e               fwd_a_o,
    output fwd_sel_e               fwd_b_o,
    output logic                   stall_o,
    output logic                   flush_id_o,
    output logic                   flush_ex_o
);

    // Youngest producer wins
    function automatic fwd_sel_e pick_src(
        input logic [REG_AW-1:0] src,
        input logic [REG_AW-1:0] mem_dest,
        input logic              mem_wr,
        input logic [REG_AW-1:0] wb_dest,
        input logic              wb_wr
    );
        if (src == '0) begin
            return FWD_RF;
        end
        if (mem_wr && mem_dest == src) begin
            return FWD_MEM;
        end
        if (wb_wr && wb_dest == src) begin
            return FWD_WB;
        end
        return FWD_RF;
    endfunction

    assign fwd_a_o = pick_src(ex_rs_i, mem_dest_i, mem_reg_wr_i, wb_dest_i, wb_reg_wr_i);
    assign fwd_b_o = pick_src(ex_rt_i, mem_dest_i, mem_reg_wr_i, wb_dest_i, wb_reg_wr_i);

    // Load in execute feeding the instruction in issue
    assign stall_o = ex_mem_rd_i && (ex_dest_i != '0) &&
                     (ex_dest_i == id_rs_i || ex_dest_i == id_rt_i);

    // A stalled jump stays in issue and redirects once the stall clears
    assign flush_id_o = branch_taken_i || (jump_i && !stall_o);
    assign flush_ex_o = branch_taken_i || stall_o;

endmodule

`default_nettype wire

// ==== rtl/mips_isa_pkg.sv ====
// Encodings for the twelve supported instructions only and no exception or coprocessor codes
`default_nettype none

package mips_isa_pkg;

    localparam int XLEN       = 32;
    localparam int REG_AW     = 5;
    localparam int SHAMT_W    = 5;
    localparam int IMEM_DEPTH = 256;
    localparam int DMEM_DEPTH = 256;

    // Instruction field positions
    localparam int OPC_LSB   = 26;
    localparam int OPC_W     = 6;
    localparam int RS_LSB    = 21;
    localparam int RT_LSB    = 16;
    localparam int RD_LSB    = 11;
    localparam int SHAMT_LSB = 6;
    localparam int FUNCT_W   = 6;
    localparam int IMM_W     = 16;
    localparam int TGT_W     = 26;

    localparam logic [OPC_W-1:0] OP_RTYPE = 6'h00;
    localparam logic [OPC_W-1:0] OP_J     = 6'h02;
    localparam logic [OPC_W-1:0] OP_BEQ   = 6'h04;
    localparam logic [OPC_W-1:0] OP_BNE   = 6'h05;
    localparam logic [OPC_W-1:0] OP_ADDIU = 6'h09;
    localparam logic [OPC_W-1:0] OP_LW    = 6'h23;
    localparam logic [OPC_W-1:0] OP_SW    = 6'h2b;

    localparam logic [FUNCT_W-1:0] F_SLL  = 6'h00;
    localparam logic [FUNCT_W-1:0] F_ADDU = 6'h21;
    localparam logic [FUNCT_W-1:0] F_SUBU = 6'h23;
    localparam logic [FUNCT_W-1:0] F_AND  = 6'h24;
    localparam logic [FUNCT_W-1:0] F_OR   = 6'h25;
    localparam logic [FUNCT_W-1:0] F_SLT  = 6'h2a;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4,
        ALU_SLL = 3'd5
    } alu_op_e;

    // Second ALU operand
    typedef enum logic [1:0] {
        SRC_REG   = 2'd0,
        SRC_IMM   = 2'd1,
        SRC_SHAMT = 2'd2
    } alu_src_e;

endpackage

`default_nettype wire

// ==== rtl/mips_pipe_top.sv ====
// Branches predicted not taken; imem should only be written while run_i is low
`timescale 1ns/1ps
`default_nettype none

module mips_pipe_top import mips_isa_pkg::*, pipe_pkg::*; (
    input  wire logic            clk,
    input  wire logic            rst_n_i,
    input  wire logic            run_i,
    input  wire logic            imem_we_i,
    input  wire logic [XLEN-1:0] imem_addr_i,
    input  wire logic [XLEN-1:0] imem_wdata_i,
    output retire_t              retire_o
);

    logic [XLEN-1:0]    pc;
    logic               fetch_valid;
    logic [XLEN-1:0]    fetch_instr;
    if_id_t             if_id_d;
    if_id_t             if_id_q;

    ctrl_t              id_ctrl;
    logic [REG_AW-1:0]  id_rs;
    logic [REG_AW-1:0]  id_rt;
    logic [REG_AW-1:0]  id_dest;
    logic [XLEN-1:0]    id_sign_imm;
    logic [SHAMT_W-1:0] id_shamt;
    logic [TGT_W+1:0]   id_jump_off;
    logic [XLEN-1:0]    id_rs_val;
    logic [XLEN-1:0]    id_rt_val;
    logic [XLEN-1:0]    id_pc_plus4;
    logic [XLEN-1:0]    jump_target;
    logic               id_jump;
    id_ex_t             id_ex_d;
    id_ex_t             id_ex_q;

    fwd_sel_e           fwd_a;
    fwd_sel_e           fwd_b;
    logic [XLEN-1:0]    ex_op_a;
    logic [XLEN-1:0]    ex_rt_fwd;
    logic [XLEN-1:0]    ex_op_b;
    logic [XLEN-1:0]    ex_result;
    logic               ex_zero;
    logic               branch_taken;
    logic [XLEN-1:0]    branch_target;
    ex_mem_t            ex_mem_d;
    ex_mem_t            ex_mem_q;

    logic [XLEN-1:0]    dmem_rdata;
    mem_wb_t            mem_wb_d;
    mem_wb_t            mem_wb_q;
    logic [XLEN-1:0]    wb_data;

    logic               stall;
    logic               flush_id;
    logic               flush_ex;

    function automatic logic [XLEN-1:0] fwd_mux(
        input fwd_sel_e        sel,
        input logic [XLEN-1:0] rf_val,
        input logic [XLEN-1:0] mem_val,
        input logic [XLEN-1:0] wb_val
    );
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return rf_val;
        endcase
    endfunction

    // Fetch
    fetch_stage fetch_stage_i (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .run_i           (run_i),
        .stall_i         (stall),
        .jump_i          (id_jump),
        .jump_target_i   (jump_target),
        .branch_taken_i  (branch_taken),
        .branch_target_i (branch_target),
        .pc_o            (pc),
        .fetch_valid_o   (fetch_valid)
    );

    word_ram #(.DEPTH(IMEM_DEPTH)) imem_i (
        .clk     (clk),
        .we_i    (imem_we_i),
        .waddr_i (imem_addr_i),
        .wdata_i (imem_wdata_i),
        .raddr_i (pc),
        .rdata_o (fetch_instr)
    );

    assign if_id_d = '{valid: fetch_valid, pc: pc, instr: fetch_instr};

    pipe_reg #(.payload_t(if_id_t)) if_id_reg_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .hold_i  (stall),
        .clear_i (flush_id),
        .d_i     (if_id_d),
        .q_o     (if_id_q)
    );

    // Issue
    decode decode_i (
        .instr_i       (if_id_q.instr),
        .ctrl_o        (id_ctrl),
        .rs_o          (id_rs),
        .rt_o          (id_rt),
        .dest_o        (id_dest),
        .sign_imm_o    (id_sign_imm),
        .shamt_o       (id_shamt),
        .jump_target_o (id_jump_off)
    );

    regfile regfile_i (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .we_i      (mem_wb_q.valid & mem_wb_q.reg_wr),
        .waddr_i   (mem_wb_q.dest),
        .wdata_i   (wb_data),
        .raddr_a_i (id_rs),
        .raddr_b_i (id_rt),
        .rdata_a_o (id_rs_val),
        .rdata_b_o (id_rt_val)
    );

    assign id_pc_plus4 = if_id_q.pc + 32'd4;
    assign jump_target = {id_pc_plus4[XLEN-1:TGT_W+2], id_jump_off};
    assign id_jump     = if_id_q.valid & id_ctrl.jump;

    // Bubbles carry no control so they never write or forward
    always_comb begin
        id_ex_d.valid    = if_id_q.valid;
        id_ex_d.ctrl     = if_id_q.valid ? id_ctrl : ctrl_t'('0);
        id_ex_d.pc       = if_id_q.pc;
        id_ex_d.rs       = id_rs;
        id_ex_d.rt       = id_rt;
        id_ex_d.dest     = if_id_q.valid ? id_dest : '0;
        id_ex_d.rs_val   = id_rs_val;
        id_ex_d.rt_val   = id_rt_val;
        id_ex_d.sign_imm = id_sign_imm;
        id_ex_d.shamt    = id_shamt;
    end

    pipe_reg #(.payload_t(id_ex_t)) id_ex_reg_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .hold_i  (1'b0),
        .clear_i (flush_ex),
        .d_i     (id_ex_d),
        .q_o     (id_ex_q)
    );

    // Execute
    assign ex_op_a   = fwd_mux(fwd_a, id_ex_q.rs_val, ex_mem_q.alu_res, wb_data);
    assign ex_rt_fwd = fwd_mux(fwd_b, id_ex_q.rt_val, ex_mem_q.alu_res, wb_data);

    always_comb begin
        case (id_ex_q.ctrl.alu_src)
            SRC_IMM:   ex_op_b = id_ex_q.sign_imm;
            SRC_SHAMT: ex_op_b = {{(XLEN-SHAMT_W){1'b0}}, id_ex_q.shamt};
            default:   ex_op_b = ex_rt_fwd;
        endcase
    end

    alu alu_i (
        .a_i      (ex_op_a),
        .b_i      (ex_op_b),
        .op_i     (id_ex_q.ctrl.alu_op),
        .result_o (ex_result),
        .zero_o   (ex_zero)
    );

    assign branch_taken  = id_ex_q.valid & id_ex_q.ctrl.branch &
                           (ex_zero ^ id_ex_q.ctrl.branch_ne);
    assign branch_target = id_ex_q.pc + 32'd4 + {id_ex_q.sign_imm[XLEN-3:0], 2'b00};

    always_comb begin
        ex_mem_d.valid      = id_ex_q.valid;
        ex_mem_d.reg_wr     = id_ex_q.ctrl.reg_wr;
        ex_mem_d.mem_rd     = id_ex_q.ctrl.mem_rd;
        ex_mem_d.mem_wr     = id_ex_q.ctrl.mem_wr;
        ex_mem_d.mem_to_reg = id_ex_q.ctrl.mem_to_reg;
        ex_mem_d.dest       = id_ex_q.dest;
        ex_mem_d.alu_res    = ex_result;
        ex_mem_d.store_data = ex_rt_fwd;
        ex_mem_d.pc         = id_ex_q.pc;
    end

    pipe_reg #(.payload_t(ex_mem_t)) ex_mem_reg_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .hold_i  (1'b0),
        .clear_i (1'b0),
        .d_i     (ex_mem_d),
        .q_o     (ex_mem_q)
    );

    // Memory
    word_ram #(.DEPTH(DMEM_DEPTH)) dmem_i (
        .clk     (clk),
        .we_i    (ex_mem_q.valid & ex_mem_q.mem_wr),
        .waddr_i (ex_mem_q.alu_res),
        .wdata_i (ex_mem_q.store_data),
        .raddr_i (ex_mem_q.alu_res),
        .rdata_o (dmem_rdata)
    );

    always_comb begin
        mem_wb_d.valid      = ex_mem_q.valid;
        mem_wb_d.reg_wr     = ex_mem_q.reg_wr;
        mem_wb_d.mem_to_reg = ex_mem_q.mem_to_reg;
        mem_wb_d.dest       = ex_mem_q.dest;
        mem_wb_d.alu_res    = ex_mem_q.alu_res;
        mem_wb_d.load_data  = dmem_rdata;
        mem_wb_d.pc         = ex_mem_q.pc;
    end

    pipe_reg #(.payload_t(mem_wb_t)) mem_wb_reg_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .hold_i  (1'b0),
        .clear_i (1'b0),
        .d_i     (mem_wb_d),
        .q_o     (mem_wb_q)
    );

    // Writeback and retire
    assign wb_data = mem_wb_q.mem_to_reg ? mem_wb_q.load_data : mem_wb_q.alu_res;

    always_comb begin
        retire_o.valid  = mem_wb_q.valid;
        retire_o.reg_wr = mem_wb_q.reg_wr;
        retire_o.rd     = mem_wb_q.dest;
        retire_o.wdata  = (mem_wb_q.dest == '0) ? '0 : wb_data;
        retire_o.pc     = mem_wb_q.pc;
    end

    hazard_unit hazard_unit_i (
        .ex_rs_i        (id_ex_q.rs),
        .ex_rt_i        (id_ex_q.rt),
        .id_rs_i        (id_rs),
        .id_rt_i        (id_rt),
        .ex_dest_i      (id_ex_q.dest),
        .ex_mem_rd_i    (id_ex_q.ctrl.mem_rd),
        .mem_dest_i     (ex_mem_q.dest),
        .mem_reg_wr_i   (ex_mem_q.reg_wr & ~ex_mem_q.mem_rd),
        .wb_dest_i      (mem_wb_q.dest),
        .wb_reg_wr_i    (mem_wb_q.reg_wr),
        .branch_taken_i (branch_taken),
        .jump_i         (id_jump),
        .fwd_a_o        (fwd_a),
        .fwd_b_o        (fwd_b),
        .stall_o        (stall),
        .flush_id_o     (flush_id),
        .flush_ex_o     (flush_ex)
    );

endmodule

`default_nettype wire

// ==== rtl/pipe_pkg.sv ====
// Stage boundary records assume an all-zero value is a bubble with no side effects
`default_nettype none

package pipe_pkg;

    import mips_isa_pkg::*;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } if_id_t;

    typedef struct packed {
        logic     reg_wr;
        logic     mem_rd;
        logic     mem_wr;
        logic     mem_to_reg;
        logic     branch;
        logic     branch_ne;
        logic     jump;
        alu_op_e  alu_op;
        alu_src_e alu_src;
    } ctrl_t;

    typedef struct packed {
        logic               valid;
        ctrl_t              ctrl;
        logic [XLEN-1:0]    pc;
        logic [REG_AW-1:0]  rs;
        logic [REG_AW-1:0]  rt;
        logic [REG_AW-1:0]  dest;
        logic [XLEN-1:0]    rs_val;
        logic [XLEN-1:0]    rt_val;
        logic [XLEN-1:0]    sign_imm;
        logic [SHAMT_W-1:0] shamt;
    } id_ex_t;

    typedef struct packed {
        logic              valid;
        logic              reg_wr;
        logic              mem_rd;
        logic              mem_wr;
        logic              mem_to_reg;
        logic [REG_AW-1:0] dest;
        logic [XLEN-1:0]   alu_res;
        logic [XLEN-1:0]   store_data;
        logic [XLEN-1:0]   pc;
    } ex_mem_t;

    typedef struct packed {
        logic              valid;
        logic              reg_wr;
        logic              mem_to_reg;
        logic [REG_AW-1:0] dest;
        logic [XLEN-1:0]   alu_res;
        logic [XLEN-1:0]   load_data;
        logic [XLEN-1:0]   pc;
    } mem_wb_t;

    // One record per completed instruction
    typedef struct packed {
        logic              valid;
        logic              reg_wr;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   wdata;
        logic [XLEN-1:0]   pc;
    } retire_t;

    typedef enum logic [1:0] {
        FWD_RF  = 2'd0,
        FWD_MEM = 2'd1,
        FWD_WB  = 2'd2
    } fwd_sel_e;

endpackage

`default_nettype wire

// ==== rtl/pipe_reg.sv ====
// Clear has priority over hold; reset and clear load an all-zero payload
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  wire logic     clk,
    input  wire logic     rst_n_i,
    input  wire logic     hold_i,
    input  wire logic     clear_i,
    input  wire payload_t d_i,
    output payload_t      q_o
);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            q_o <= '0;
        end else if (clear_i) begin
            q_o <= '0;
        end else if (!hold_i) begin
            q_o <= d_i;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/regfile.sv ====
// r0 reads zero and ignores writes; a same-cycle write is visible on both read ports
`timescale 1ns/1ps
`default_nettype none

module regfile import mips_isa_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst_n_i,
    input  wire logic              we_i,
    input  wire logic [REG_AW-1:0] waddr_i,
    input  wire logic [XLEN-1:0]   wdata_i,
    input  wire logic [REG_AW-1:0] raddr_a_i,
    input  wire logic [REG_AW-1:0] raddr_b_i,
    output logic      [XLEN-1:0]   rdata_a_o,
    output logic      [XLEN-1:0]   rdata_b_o
);

    logic [XLEN-1:0] regs [2**REG_AW];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 2**REG_AW; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Write-through covers the writeback to issue distance
    assign rdata_a_o = (raddr_a_i == '0) ? '0 :
                       (we_i && raddr_a_i == waddr_i) ? wdata_i : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 :
                       (we_i && raddr_b_i == waddr_i) ? wdata_i : regs[raddr_b_i];

endmodule

`default_nettype wire

// ==== rtl/word_ram.sv ====
// Word access only with no byte strobes; address bits above the array size are ignored
`timescale 1ns/1ps
`default_nettype none

module word_ram import mips_isa_pkg::*; #(
    parameter int DEPTH = 256
) (
    input  wire logic            clk,
    input  wire logic            we_i,
    input  wire logic [XLEN-1:0] waddr_i,
    input  wire logic [XLEN-1:0] wdata_i,
    input  wire logic [XLEN-1:0] raddr_i,
    output logic      [XLEN-1:0] rdata_o
);

    localparam int AW = $clog2(DEPTH);

    logic [XLEN-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i[AW+1:2]] <= wdata_i;
        end
    end

    assign rdata_o = mem[raddr_i[AW+1:2]];

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the pipeline testbench; exit status follows the simulation
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -f src.f --top-module mips_pipe_tb -o mips_pipe_sim \
    && ./obj_dir/mips_pipe_sim \
    || exit 1

// ==== src.f ====
rtl/mips_isa_pkg.sv
rtl/pipe_pkg.sv
rtl/fetch_stage.sv
rtl/decode.sv
rtl/regfile.sv
rtl/alu.sv
rtl/hazard_unit.sv
rtl/pipe_reg.sv
rtl/word_ram.sv
rtl/mips_pipe_top.sv
verification/mips_pipe_props.sv
verification/mips_pipe_tb.sv

// ==== verification/mips_pipe_props.sv ====
// Bound into the pipeline top level; checks retire, stall and branch redirect rules
`timescale 1ns/1ps
`default_nettype none

module mips_pipe_props import mips_isa_pkg::*, pipe_pkg::*; (
    input wire logic            clk,
    input wire logic            rst_n_i,
    input wire logic            run_i,
    input wire logic            stall_i,
    input wire logic            branch_taken_i,
    input wire logic [XLEN-1:0] pc_i,
    input wire logic [XLEN-1:0] branch_target_i,
    input wire logic [XLEN-1:0] r0_i,
    input wire retire_t         retire_i
);

    idle_in_reset: assert property (@(posedge clk) !rst_n_i |-> !retire_i.valid)
        else $error("retire valid during reset");

    // A retired write naming r0 leaves the register itself at zero
    r0_stays_zero: assert property (@(posedge clk) disable iff (!rst_n_i)
        (retire_i.valid && retire_i.reg_wr && retire_i.rd == '0) |=> r0_i == '0)
        else $error("register r0 overwritten by a retired write");

    // A load-use stall freezes the pc unless a branch redirects it
    stall_holds_pc: assert property (@(posedge clk) disable iff (!rst_n_i)
        (run_i && stall_i && !branch_taken_i) |=> pc_i == $past(pc_i))
        else $error("pc advanced during stall");

    branch_redirects: assert property (@(posedge clk) disable iff (!rst_n_i)
        (run_i && branch_taken_i) |=> pc_i == $past(branch_target_i))
        else $error("taken branch did not redirect fetch");

endmodule

`default_nettype wire

// ==== verification/mips_pipe_tb.sv ====
// Runs one fixed program with LFSR-chosen immediates; stops at the first mismatch or at the cycle limit
`timescale 1ns/1ps
`default_nettype none

module mips_pipe_tb import mips_isa_pkg::*, pipe_pkg::*; ();

    localparam int PROG_LEN    = 24;
    localparam int CYCLE_LIMIT = 4 * PROG_LEN + 30;

    logic            clk = 1'b0;
    logic            rst_n_i;
    logic            run_i;
    logic            imem_we_i;
    logic [XLEN-1:0] imem_addr_i;
    logic [XLEN-1:0] imem_wdata_i;
    retire_t         retire_o;

    logic [XLEN-1:0] prog [IMEM_DEPTH];
    retire_t         exp_q [$];
    logic [15:0]     lfsr_state = 16'd53;
    int              run_cycles = 0;

    mips_pipe_top mips_pipe_top_i (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .run_i        (run_i),
        .imem_we_i    (imem_we_i),
        .imem_addr_i  (imem_addr_i),
        .imem_wdata_i (imem_wdata_i),
        .retire_o     (retire_o)
    );

    always #50 clk = ~clk;

    // Galois LFSR, one step per bit taken
    function automatic logic [XLEN-1:0] take_bits(input int n);
        logic [XLEN-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
            v = {v[XLEN-2:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [XLEN-1:0] enc_r(input int funct, input int rd, input int rs,
                                              input int rt, input int shamt);
        return {OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], shamt[4:0], funct[5:0]};
    endfunction

    function automatic logic [XLEN-1:0] enc_i(input logic [5:0] op, input int rt, input int rs,
                                              input logic [XLEN-1:0] imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic logic [XLEN-1:0] enc_j(input int word_idx);
        return {OP_J, word_idx[25:0]};
    endfunction

    function automatic void build_program();
        logic [XLEN-1:0] imm_neg;
        logic [XLEN-1:0] shamt;
        logic [XLEN-1:0] offs;
        imm_neg = take_bits(15) | 32'h8000;
        shamt   = take_bits(5);
        offs    = take_bits(6) << 2;
        prog[0]  = enc_i(OP_ADDIU, 1, 0, take_bits(16));
        prog[1]  = enc_i(OP_ADDIU, 2, 0, take_bits(15));
        prog[2]  = enc_i(OP_ADDIU, 3, 1, imm_neg);
        // Dependent chain through both forward paths
        prog[3]  = enc_r(F_ADDU, 4, 3, 2, 0);
        prog[4]  = enc_r(F_SUBU, 5, 4, 1, 0);
        prog[5]  = enc_r(F_AND, 6, 5, 4, 0);
        prog[6]  = enc_r(F_OR, 7, 6, 3, 0);
        prog[7]  = enc_r(F_SLT, 8, 7, 5, 0);
        prog[8]  = enc_r(F_SLL, 9, 0, 7, shamt);
        prog[9]  = enc_r(F_ADDU, 0, 9, 4, 0);
        prog[10] = enc_r(F_OR, 10, 0, 9, 0);
        prog[11] = enc_i(OP_SW, 7, 0, offs);
        prog[12] = enc_i(OP_LW, 11, 0, offs);
        prog[13] = enc_r(F_ADDU, 12, 11, 1, 0);
        prog[14] = enc_i(OP_BEQ, 7, 11, 32'd2);
        prog[15] = enc_i(OP_ADDIU, 13, 0, 32'd1);
        prog[16] = enc_i(OP_ADDIU, 14, 0, 32'd2);
        prog[17] = enc_i(OP_BNE, 1, 1, 32'd5);
        prog[18] = enc_i(OP_BNE, 11, 12, 32'd1);
        prog[19] = enc_i(OP_ADDIU, 15, 0, 32'd3);
        prog[20] = enc_j(22);
        prog[21] = enc_i(OP_ADDIU, 16, 0, 32'd4);
        prog[22] = enc_r(F_ADDU, 17, 15, 12, 0);
        prog[23] = enc_j(23);
    endfunction

    // Instruction-set model without delay slots; ends after the first self-jump
    function automatic void run_reference();
        logic [XLEN-1:0] regs [32];
        logic [XLEN-1:0] dmem [DMEM_DEPTH];
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] npc;
        logic [XLEN-1:0] ins;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] sext;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] res;
        logic [5:0]      op;
        logic [4:0]      dest;
        logic            wr;
        logic            done;
        retire_t         rec;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        pc   = '0;
        done = 1'b0;
        while (!done) begin
            ins  = prog[pc[9:2]];
            op   = ins[31:26];
            a    = regs[ins[25:21]];
            b    = regs[ins[20:16]];
            sext = {{16{ins[15]}}, ins[15:0]};
            addr = a + sext;
            npc  = pc + 32'd4;
            wr   = 1'b0;
            dest = '0;
            res  = '0;
            case (op)
                OP_RTYPE: begin
                    wr   = 1'b1;
                    dest = ins[15:11];
                    case (ins[5:0])
                        F_ADDU:  res = a + b;
                        F_SUBU:  res = a - b;
                        F_AND:   res = a & b;
                        F_OR:    res = a | b;
                        F_SLT:   res = {31'b0, $signed(a) < $signed(b)};
                        default: res = b << ins[10:6];
                    endcase
                end
                OP_ADDIU: begin
                    wr   = 1'b1;
                    dest = ins[20:16];
                    res  = addr;
                end
                OP_LW: begin
                    wr   = 1'b1;
                    dest = ins[20:16];
                    res  = dmem[addr[9:2]];
                end
                OP_SW:  dmem[addr[9:2]] = b;
                OP_BEQ: npc = (a == b) ? pc + 32'd4 + (sext << 2) : npc;
                OP_BNE: npc = (a != b) ? pc + 32'd4 + (sext << 2) : npc;
                default: begin
                    npc  = {npc[31:28], ins[25:0], 2'b00};
                    done = (npc == pc);
                end
            endcase
            if (wr && dest != 0) begin
                regs[dest] = res;
            end
            rec.valid  = 1'b1;
            rec.reg_wr = wr;
            rec.rd     = dest;
            rec.wdata  = (dest == 0) ? '0 : res;
            rec.pc     = pc;
            exp_q.push_back(rec);
            pc = npc;
        end
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check(input string name, input logic [XLEN-1:0] expected,
                         input logic [XLEN-1:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("[FAIL] %s expected %h actual %h", name, expected, actual));
        end
    endtask

    initial begin
        rst_n_i      = 1'b0;
        run_i        = 1'b0;
        imem_we_i    = 1'b0;
        imem_addr_i  = '0;
        imem_wdata_i = '0;
        build_program();
        run_reference();
        repeat (2) @(posedge clk);
        #1 rst_n_i = 1'b1;
        for (int i = 0; i < PROG_LEN; i++) begin
            @(posedge clk);
            #1;
            imem_we_i    = 1'b1;
            imem_addr_i  = 32'(i * 4);
            imem_wdata_i = prog[i];
        end
        @(posedge clk);
        #1 imem_we_i = 1'b0;
        repeat (3) @(posedge clk);
        #1 run_i = 1'b1;
    end

    // Nothing may retire before the pipeline is started
    always @(negedge clk) begin
        if (!run_i) begin
            check("idle retire", '0, 32'(retire_o.valid));
        end
    end

    always @(posedge clk) begin
        if (run_i) begin
            run_cycles++;
            if (run_cycles > CYCLE_LIMIT) begin
                abort_run("Timeout: the program did not retire within the cycle limit");
            end
        end
    end

    initial begin : compare_retires
        int      idx;
        retire_t exp;
        idx = 0;
        wait (run_i === 1'b1);
        while (idx < exp_q.size()) begin
            @(negedge clk);
            if (retire_o.valid) begin
                exp = exp_q[idx];
                check($sformatf("retire %0d pc", idx), exp.pc, retire_o.pc);
                check($sformatf("retire %0d reg_wr", idx), 32'(exp.reg_wr),
                      32'(retire_o.reg_wr));
                check($sformatf("retire %0d rd", idx), 32'(exp.rd), 32'(retire_o.rd));
                check($sformatf("retire %0d wdata", idx), exp.wdata, retire_o.wdata);
                idx++;
            end
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

bind mips_pipe_top mips_pipe_props mips_pipe_props_i (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .run_i           (run_i),
    .stall_i         (stall),
    .branch_taken_i  (branch_taken),
    .pc_i            (pc),
    .branch_target_i (branch_target),
    .r0_i            (regfile_i.regs[0]),
    .retire_i        (retire_o)
);

`default_nettype wire
